// ==== list.f ====
+incdir+include
hdl/soc_pkg.sv
hdl/periph_if.sv
hdl/data_mem.sv
hdl/instr_mem.sv
hdl/timer.sv
hdl/gpio.sv
hdl/soc_bus.sv
dv/soc_checker.sv
dv/tb_soc.sv

// ==== Makefile ====
TOP = tb_soc

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log, check the result"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/soc_golden.txt ====
# op addr be data exp name, all numbers hex; a read compares (rdata & data) with exp
# ack drives data as irq id and expects irq_7_o == exp; setpin reads its pins back at addr
write 00000010 f 11223344 00000000 dmem_full_wr
read 00000010 f ffffffff 11223344 dmem_full_rd
write 00000010 1 000000aa 00000000 dmem_lane0
write 00000010 4 00cc0000 00000000 dmem_lane2
read 00000010 f ffffffff 11cc33aa dmem_merge_a
write 00000010 2 0000bb00 00000000 dmem_lane1
write 00000010 8 dd000000 00000000 dmem_lane3
read 00000010 f ffffffff ddccbbaa dmem_merge_b
write 00000020 f cafef00d 00000000 dmem_base
write 00002020 f deadbeef 00000000 dec_wr_r1
write 00006020 f deadbeef 00000000 dec_wr_r3
write 00008020 f deadbeef 00000000 dec_wr_r4
write 0000a020 f deadbeef 00000000 dec_wr_r5
write 0000e020 f deadbeef 00000000 dec_wr_r7
write 00012020 f deadbeef 00000000 dec_wr_r9
write 0001e020 f deadbeef 00000000 dec_wr_r15
read 00002020 f ffffffff 00000000 dec_rd_r1
read 00006020 f ffffffff 00000000 dec_rd_r3
read 00008020 f ffffffff 00000000 dec_rd_r4
read 0000a020 f ffffffff 00000000 dec_rd_r5
read 0000e020 f ffffffff 00000000 dec_rd_r7
read 00012020 f ffffffff 00000000 dec_rd_r9
read 0001e020 f ffffffff 00000000 dec_rd_r15
read 00000020 f ffffffff cafef00d dec_dmem_kept
write 00004000 f 00000013 00000000 imem_wr0
write 00004004 f 00a00093 00000000 imem_wr1
write 00004ffc 3 12345678 00000000 imem_wr_last
fetch 00000000 0 00000000 00000013 imem_fetch0
fetch 00000004 0 00000000 00a00093 imem_fetch1
fetch 00000ffc 0 00000000 12345678 imem_fetch_last
read 00004000 f ffffffff 00000000 imem_data_rd
write 00010000 f a5a55a5a 00000000 gpio_out_wr
read 00010000 f ffffffff 00005a5a gpio_out_rd
write 00010000 4 ffff0000 00000000 gpio_lane2_wr
read 00010000 f ffffffff 00005a5a gpio_lane2_rd
write 00010000 2 00003c00 00000000 gpio_lane1_wr
read 00010000 f ffffffff 00003c5a gpio_lane1_rd
setpin 00010004 f 00000000 00000000 gpio_pins_a
setpin 00010004 f 00000000 00000000 gpio_pins_b
write 0000c004 f 00000040 00000000 tmr_cmp_wr
read 0000c004 f ffffffff 00000040 tmr_cmp_rd
write 0000c008 f 00000003 00000000 tmr_ctrl_wr
read 0000c008 f ffffffff 00000003 tmr_ctrl_rd
waitirq 00000000 0 00000000 00000000 tmr_wait
read 0000c000 f ffffffc0 00000000 tmr_count_below
ack 00000000 0 00000003 00000001 tmr_ack_other
ack 00000000 0 00000007 00000000 tmr_ack_own
write 0000c008 f 00000000 00000000 tmr_stop
read 00000010 f ffffffff ddccbbaa b2b_dmem
read 00010000 f ffffffff 00003c5a b2b_gpio
read 0000c004 f ffffffff 00000040 b2b_timer
read 00006000 f ffffffff 00000000 b2b_uart
read 00000020 f ffffffff cafef00d b2b_dmem_base

// ==== dv/tb_soc.sv ====
`timescale 1ns/100ps

module tb_soc;
    import soc_pkg::*;

    localparam int IRQ_TIMEOUT = 400;
    localparam int DRAIN_TIMEOUT = 20;

    logic                clk_i;
    logic                rst_i;
    logic                data_req_i;
    logic                data_we_i;
    logic [BE_W-1:0]     data_be_i;
    logic [ADDR_W-1:0]   data_addr_i;
    logic [DATA_W-1:0]   data_wdata_i;
    logic                data_gnt_o;
    logic                data_rvalid_o;
    logic [DATA_W-1:0]   data_rdata_o;
    logic                instr_req_i;
    logic [ADDR_W-1:0]   instr_addr_i;
    logic                instr_gnt_o;
    logic                instr_rvalid_o;
    logic [DATA_W-1:0]   instr_rdata_o;
    logic                irq_7_o;
    logic                irq_ack_i;
    logic [IRQ_ID_W-1:0] irq_id_i;
    logic [GPIO_W-1:0]   gpio_i;
    logic [GPIO_W-1:0]   gpio_o;
    integer              seed = 32'h3a2a;

    soc_bus UUT (.*);

    soc_checker u_checker (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (data_req_i),
        .we_i          (data_we_i),
        .be_i          (data_be_i),
        .addr_i        (data_addr_i),
        .wdata_i       (data_wdata_i),
        .gnt_i         (data_gnt_o),
        .rvalid_i      (data_rvalid_o),
        .rdata_i       (data_rdata_o),
        .fetch_req_i   (instr_req_i),
        .fetch_gnt_i   (instr_gnt_o),
        .fetch_rvalid_i(instr_rvalid_o),
        .fetch_rdata_i (instr_rdata_o),
        .irq_i         (irq_7_o),
        .pins_in_i     (gpio_i),
        .pins_out_i    (gpio_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #20 clk_i = ~clk_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic drop_strobes();
        data_req_i  = 1'b0;
        data_we_i   = 1'b0;
        instr_req_i = 1'b0;
        irq_ack_i   = 1'b0;
    endtask

    // One golden line, started on a falling edge.
    task automatic run_op(input string op, input logic [31:0] addr, input logic [31:0] be,
                          input logic [31:0] data, input logic [31:0] exp, input string name);
        int          waited;
        logic [31:0] rnd;
        @(negedge clk_i);
        drop_strobes();
        if (op == "write" || op == "read") begin
            data_req_i   = 1'b1;
            data_we_i    = (op == "write");
            data_be_i    = be[BE_W-1:0];
            data_addr_i  = addr;
            data_wdata_i = data;
            // Writes only need the rvalid pulse.
            if (op == "write") begin
                u_checker.queue_check(0, '0, '0, name);
            end else begin
                u_checker.queue_check(0, exp, data, name);
            end
        end else if (op == "fetch") begin
            instr_req_i  = 1'b1;
            instr_addr_i = addr;
            u_checker.queue_check(1, exp, '1, name);
        end else if (op == "ack") begin
            irq_ack_i = 1'b1;
            irq_id_i  = data[IRQ_ID_W-1:0];
            u_checker.queue_check(2, exp, '1, name);
        end else if (op == "setpin") begin
            rnd    = $random(seed);
            gpio_i = rnd[GPIO_W-1:0];
            // One sample cycle, then read the pins back.
            @(negedge clk_i);
            data_req_i  = 1'b1;
            data_be_i   = be[BE_W-1:0];
            data_addr_i = addr;
            u_checker.queue_pin_read(name);
        end else if (op == "waitirq") begin
            waited = 0;
            while (irq_7_o !== 1'b1 && waited < IRQ_TIMEOUT) begin
                @(posedge clk_i);
                waited++;
            end
            if (irq_7_o !== 1'b1) begin
                u_checker.note_timeout({"irq_7_o never rose in ", name});
            end
        end else begin
            u_checker.note_error({"unknown op ", op, " in ", name});
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          waited;
        string       line;
        string       op;
        string       name;
        logic [31:0] addr;
        logic [31:0] be;
        logic [31:0] data;
        logic [31:0] exp;

        rst_i        = 1'b1;
        data_be_i    = '0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        instr_addr_i = '0;
        irq_id_i     = '0;
        gpio_i       = '0;
        drop_strobes();
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;

        fd = $fopen("dv/soc_golden.txt", "r");
        if (fd == 0) begin
            u_checker.note_error("cannot open dv/soc_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %s", op, addr, be, data, exp, name);
                    if (n == 6) begin
                        run_op(op, addr, be, data, exp, name);
                    end else begin
                        u_checker.note_error({"unreadable golden line ", line});
                    end
                end
            end
            $fclose(fd);
        end

        // Let the last responses come back.
        @(negedge clk_i);
        drop_strobes();
        waited = 0;
        while (u_checker.pending() > 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            waited++;
        end
        if (u_checker.pending() > 0) begin
            u_checker.note_timeout("responses still outstanding after the last request");
        end

        $display("Mismatches %0d, other errors %0d, timeouts %0d",
                 u_checker.mismatch_cnt, u_checker.error_cnt, u_checker.timeout_cnt);
        if (u_checker.mismatch_cnt + u_checker.error_cnt + u_checker.timeout_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/soc_checker.sv ====
`timescale 1ns/100ps

`include "soc_map.svh"

module soc_checker (
    input logic                       clk_i,
    input logic                       rst_i,
    input logic                       req_i,
    input logic                       we_i,
    input logic [soc_pkg::BE_W-1:0]   be_i,
    input logic [soc_pkg::ADDR_W-1:0] addr_i,
    input logic [soc_pkg::DATA_W-1:0] wdata_i,
    input logic                       gnt_i,
    input logic                       rvalid_i,
    input logic [soc_pkg::DATA_W-1:0] rdata_i,
    input logic                       fetch_req_i,
    input logic                       fetch_gnt_i,
    input logic                       fetch_rvalid_i,
    input logic [soc_pkg::DATA_W-1:0] fetch_rdata_i,
    input logic                       irq_i,
    input logic [soc_pkg::GPIO_W-1:0] pins_in_i,
    input logic [soc_pkg::GPIO_W-1:0] pins_out_i
);
    import soc_pkg::*;

    // Pending responses, oldest first. Port 0 is data, 1 fetch, 2 irq.
    int                q_due[$];
    int                q_port[$];
    logic [DATA_W-1:0] q_exp[$];
    logic [DATA_W-1:0] q_mask[$];
    string             q_name[$];

    int                cyc = 0;
    int                mismatch_cnt = 0;
    int                error_cnt = 0;
    int                timeout_cnt = 0;
    logic [GPIO_W-1:0] pins_model;
    bit                seen_data;
    bit                seen_fetch;

    // ~~~~~~~~~~~~~~~~~~~~
    // Hooks for the stimulus side.
    // ~~~~~~~~~~~~~~~~~~~~

    // Called on the falling edge that drives the request.
    task automatic queue_check(input int port, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] mask, input string name);
        q_due.push_back(cyc + 2);
        q_port.push_back(port);
        q_exp.push_back(exp);
        q_mask.push_back(mask);
        q_name.push_back(name);
    endtask

    // Pins are stable since the last falling edge.
    task automatic queue_pin_read(input string name);
        queue_check(0, DATA_W'(pins_in_i), '1, name);
    endtask

    task automatic note_error(input string msg);
        $display("ERROR: %s", msg);
        error_cnt++;
    endtask

    task automatic note_timeout(input string msg);
        $display("TIMEOUT: %s", msg);
        timeout_cnt++;
    endtask

    function automatic int pending();
        return q_due.size();
    endfunction

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] mask, input logic [DATA_W-1:0] actual);
        if ((actual & mask) !== exp) begin
            $display("Mismatch %s: expected %h actual %h", name, exp, actual);
            mismatch_cnt++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Port monitor.
    // ~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk_i) begin
        cyc = cyc + 1;
        seen_data = 1'b0;
        seen_fetch = 1'b0;
        if (rst_i) begin
            pins_model = '0;
        end else begin
            while (q_due.size() > 0 && q_due[0] == cyc) begin
                case (q_port[0])
                    0: begin
                        seen_data = 1'b1;
                        if (rvalid_i !== 1'b1) begin
                            note_error({"data_rvalid_o missing for ", q_name[0]});
                        end else begin
                            check_word(q_name[0], q_exp[0], q_mask[0], rdata_i);
                        end
                    end
                    1: begin
                        seen_fetch = 1'b1;
                        if (fetch_rvalid_i !== 1'b1) begin
                            note_error({"instr_rvalid_o missing for ", q_name[0]});
                        end else begin
                            check_word(q_name[0], q_exp[0], q_mask[0], fetch_rdata_i);
                        end
                    end
                    default: begin
                        check_word(q_name[0], q_exp[0], q_mask[0], DATA_W'(irq_i));
                    end
                endcase
                void'(q_due.pop_front());
                void'(q_port.pop_front());
                void'(q_exp.pop_front());
                void'(q_mask.pop_front());
                void'(q_name.pop_front());
            end

            if (!seen_data && rvalid_i !== 1'b0) begin
                note_error("data_rvalid_o high without a request");
            end
            if (!seen_fetch && fetch_rvalid_i !== 1'b0) begin
                note_error("instr_rvalid_o high without a request");
            end
            if (req_i && gnt_i !== 1'b1) begin
                note_error("data_gnt_o low during a request");
            end
            if (fetch_gnt_i !== fetch_req_i) begin
                note_error("instr_gnt_o does not follow instr_req_i");
            end

            // Output pins against a model of lanes 0 and 1.
            check_word("gpio_out", DATA_W'(pins_model), '1, DATA_W'(pins_out_i));
            if (req_i && we_i && addr_i[REGION_MSB:REGION_LSB] == `REGION_GPIO
                    && {addr_i[PERIPH_ADDR_W-1:2], 2'b00} == `GPIO_OUT) begin
                if (be_i[0]) begin
                    pins_model[7:0] = wdata_i[7:0];
                end
                if (be_i[1]) begin
                    pins_model[15:8] = wdata_i[15:8];
                end
            end
        end
    end

endmodule

// ==== hdl/soc_bus.sv ====
`timescale 1ns/100ps

`include "soc_map.svh"

module soc_bus #(
    parameter int DMEM_WORDS = 2048,
    parameter int IMEM_WORDS = 4096
) (
    input  logic                         clk_i,
    input  logic                         rst_i,

    input  logic                         data_req_i,
    input  logic                         data_we_i,
    input  logic [soc_pkg::BE_W-1:0]     data_be_i,
    input  logic [soc_pkg::ADDR_W-1:0]   data_addr_i,
    input  logic [soc_pkg::DATA_W-1:0]   data_wdata_i,
    output logic                         data_gnt_o,
    output logic                         data_rvalid_o,
    output logic [soc_pkg::DATA_W-1:0]   data_rdata_o,

    input  logic                         instr_req_i,
    input  logic [soc_pkg::ADDR_W-1:0]   instr_addr_i,
    output logic                         instr_gnt_o,
    output logic                         instr_rvalid_o,
    output logic [soc_pkg::DATA_W-1:0]   instr_rdata_o,

    output logic                         irq_7_o,
    input  logic                         irq_ack_i,
    input  logic [soc_pkg::IRQ_ID_W-1:0] irq_id_i,

    input  logic [soc_pkg::GPIO_W-1:0]   gpio_i,
    output logic [soc_pkg::GPIO_W-1:0]   gpio_o
);
    import soc_pkg::*;

    region_t           region;
    logic              wr_req;
    logic              sel_dmem;
    logic              sel_imem;
    logic              sel_timer;
    logic              sel_gpio;
    logic [DATA_W-1:0] rdata_next;

    periph_if dmem_bus ();
    periph_if imem_bus ();
    periph_if timer_bus ();
    periph_if gpio_bus ();

    // ~~~~~~~~~~~~~~~~~~~~
    // Region decode.
    // ~~~~~~~~~~~~~~~~~~~~

    // Every request is granted at once.
    assign data_gnt_o = 1'b1;

    assign region = data_addr_i[REGION_MSB:REGION_LSB];
    assign wr_req = data_req_i & data_we_i;

    // Flash, UART, I2C, QSPI, USB and 9..15 have no select and read zero.
    assign sel_dmem  = (region == `REGION_DMEM);
    assign sel_imem  = (region == `REGION_IMEM);
    assign sel_timer = (region == `REGION_TIMER);
    assign sel_gpio  = (region == `REGION_GPIO);

    assign dmem_bus.wr    = wr_req & sel_dmem;
    assign dmem_bus.be    = data_be_i;
    assign dmem_bus.addr  = data_addr_i[PERIPH_ADDR_W-1:0];
    assign dmem_bus.wdata = data_wdata_i;

    assign imem_bus.wr    = wr_req & sel_imem;
    assign imem_bus.be    = data_be_i;
    assign imem_bus.addr  = data_addr_i[PERIPH_ADDR_W-1:0];
    assign imem_bus.wdata = data_wdata_i;

    assign timer_bus.wr    = wr_req & sel_timer;
    assign timer_bus.be    = data_be_i;
    assign timer_bus.addr  = data_addr_i[PERIPH_ADDR_W-1:0];
    assign timer_bus.wdata = data_wdata_i;

    assign gpio_bus.wr    = wr_req & sel_gpio;
    assign gpio_bus.be    = data_be_i;
    assign gpio_bus.addr  = data_addr_i[PERIPH_ADDR_W-1:0];
    assign gpio_bus.wdata = data_wdata_i;

    // ~~~~~~~~~~~~~~~~~~~~
    // Read data return.
    // ~~~~~~~~~~~~~~~~~~~~

    assign rdata_next = ({DATA_W{sel_dmem}}  & dmem_bus.rdata)
                      | ({DATA_W{sel_imem}}  & imem_bus.rdata)
                      | ({DATA_W{sel_timer}} & timer_bus.rdata)
                      | ({DATA_W{sel_gpio}}  & gpio_bus.rdata);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            data_rvalid_o <= 1'b0;
        end else begin
            data_rvalid_o <= data_req_i;
        end
    end

    // Writes return the old word too.
    always_ff @(posedge clk_i) begin
        if (data_req_i) begin
            data_rdata_o <= rdata_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Targets.
    // ~~~~~~~~~~~~~~~~~~~~

    data_mem #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_data_mem (
        .clk_i(clk_i),
        .bus_i(dmem_bus)
    );

    instr_mem #(
        .IMEM_WORDS(IMEM_WORDS)
    ) u_instr_mem (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .bus_i   (imem_bus),
        .req_i   (instr_req_i),
        .addr_i  (instr_addr_i),
        .gnt_o   (instr_gnt_o),
        .rvalid_o(instr_rvalid_o),
        .rdata_o (instr_rdata_o)
    );

    timer u_timer (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .bus_i    (timer_bus),
        .irq_o    (irq_7_o),
        .irq_ack_i(irq_ack_i),
        .irq_id_i (irq_id_i)
    );

    gpio u_gpio (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bus_i (gpio_bus),
        .pins_i(gpio_i),
        .pins_o(gpio_o)
    );

endmodule

// ==== hdl/gpio.sv ====
`timescale 1ns/100ps

`include "soc_map.svh"

module gpio (
    input  logic                       clk_i,
    input  logic                       rst_i,
    periph_if.dev                      bus_i,

    input  logic [soc_pkg::GPIO_W-1:0] pins_i,
    output logic [soc_pkg::GPIO_W-1:0] pins_o
);
    import soc_pkg::*;

    logic [GPIO_W-1:0] pins_q;
    logic [DATA_W-1:0] out_next;
    periph_addr_t      reg_addr;

    assign reg_addr = {bus_i.addr[PERIPH_ADDR_W-1:2], 2'b00};

    // Only the low two lanes land in the register.
    assign out_next = byte_merge(DATA_W'(pins_o), bus_i.wdata, bus_i.be);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pins_o <= '0;
        end else if (bus_i.wr && reg_addr == `GPIO_OUT) begin
            pins_o <= out_next[GPIO_W-1:0];
        end
    end

    // Input sample, one per cycle.
    always_ff @(posedge clk_i) begin
        pins_q <= pins_i;
    end

    always_comb begin
        case (reg_addr)
            `GPIO_OUT: bus_i.rdata = DATA_W'(pins_o);
            `GPIO_IN:  bus_i.rdata = DATA_W'(pins_q);
            default:   bus_i.rdata = '0;
        endcase
    end

endmodule

// ==== hdl/timer.sv ====
`timescale 1ns/100ps

`include "soc_map.svh"

module timer (
    input  logic                         clk_i,
    input  logic                         rst_i,
    periph_if.dev                        bus_i,

    output logic                         irq_o,
    input  logic                         irq_ack_i,
    input  logic [soc_pkg::IRQ_ID_W-1:0] irq_id_i
);
    import soc_pkg::*;

    logic [DATA_W-1:0] count_q;
    logic [DATA_W-1:0] compare_q;
    logic [DATA_W-1:0] ctrl_q;
    periph_addr_t      reg_addr;
    logic              count_en;
    logic              irq_en;
    logic              match;
    logic              ack;

    // Word-aligned register offset.
    assign reg_addr = {bus_i.addr[PERIPH_ADDR_W-1:2], 2'b00};

    assign count_en = ctrl_q[0];
    assign irq_en   = ctrl_q[1];
    assign match    = count_en && (count_q == compare_q);
    assign ack      = irq_ack_i && (irq_id_i == TIMER_IRQ_ID);

    // ~~~~~~~~~~~~~~~~~~~~
    // Registers.
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q   <= '0;
            compare_q <= '0;
            ctrl_q    <= '0;
        end else begin
            // Bus write to count beats the increment.
            if (bus_i.wr && reg_addr == `TMR_COUNT) begin
                count_q <= byte_merge(count_q, bus_i.wdata, bus_i.be);
            end else if (match) begin
                count_q <= '0;
            end else if (count_en) begin
                count_q <= count_q + 1'b1;
            end

            if (bus_i.wr && reg_addr == `TMR_COMPARE) begin
                compare_q <= byte_merge(compare_q, bus_i.wdata, bus_i.be);
            end
            if (bus_i.wr && reg_addr == `TMR_CTRL) begin
                ctrl_q <= byte_merge(ctrl_q, bus_i.wdata, bus_i.be);
            end
        end
    end

    // Pending flag, held until acked with our id.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            irq_o <= 1'b0;
        end else if (match && irq_en) begin
            irq_o <= 1'b1;
        end else if (ack) begin
            irq_o <= 1'b0;
        end
    end

    always_comb begin
        case (reg_addr)
            `TMR_COUNT:   bus_i.rdata = count_q;
            `TMR_COMPARE: bus_i.rdata = compare_q;
            `TMR_CTRL:    bus_i.rdata = ctrl_q;
            default:      bus_i.rdata = '0;
        endcase
    end

endmodule

// ==== hdl/instr_mem.sv ====
`timescale 1ns/100ps

module instr_mem #(
    parameter int IMEM_WORDS = 4096
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    periph_if.dev                      bus_i,

    input  logic                       req_i,
    input  logic [soc_pkg::ADDR_W-1:0] addr_i,
    output logic                       gnt_o,
    output logic                       rvalid_o,
    output logic [soc_pkg::DATA_W-1:0] rdata_o
);
    import soc_pkg::*;

    localparam int IDX_W = $clog2(IMEM_WORDS);

    logic [DATA_W-1:0] mem [IMEM_WORDS];
    logic [IDX_W-1:0]  wr_idx;
    logic [IDX_W-1:0]  fetch_idx;

    assign wr_idx    = IDX_W'(bus_i.addr[PERIPH_ADDR_W-1:2] % IMEM_WORDS);
    assign fetch_idx = IDX_W'(addr_i[ADDR_W-1:2] % IMEM_WORDS);

    // ~~~~~~~~~~~~~~~~~~~~
    // Load port.
    // ~~~~~~~~~~~~~~~~~~~~

    // Program loading is always word-wide.
    always_ff @(posedge clk_i) begin
        if (bus_i.wr) begin
            mem[wr_idx] <= bus_i.wdata;
        end
    end

    // Not readable from the data side.
    assign bus_i.rdata = '0;

    // ~~~~~~~~~~~~~~~~~~~~
    // Fetch port.
    // ~~~~~~~~~~~~~~~~~~~~

    assign gnt_o = req_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= mem[fetch_idx];
        end
    end

endmodule

// ==== hdl/data_mem.sv ====
`timescale 1ns/100ps

module data_mem #(
    parameter int DMEM_WORDS = 2048
) (
    input  logic   clk_i,
    periph_if.dev  bus_i
);
    import soc_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [DATA_W-1:0] mem [DMEM_WORDS];
    logic [IDX_W-1:0]  idx;

    // Word index, wraps at the array size.
    assign idx = IDX_W'(bus_i.addr[PERIPH_ADDR_W-1:2] % DMEM_WORDS);

    always_ff @(posedge clk_i) begin
        if (bus_i.wr) begin
            for (int lane = 0; lane < BE_W; lane++) begin
                if (bus_i.be[lane]) begin
                    mem[idx][8*lane +: 8] <= bus_i.wdata[8*lane +: 8];
                end
            end
        end
    end

    // Asynchronous read.
    assign bus_i.rdata = mem[idx];

endmodule

// ==== hdl/periph_if.sv ====
`timescale 1ns/100ps

interface periph_if;
    import soc_pkg::*;

    // Write strobe, already qualified by region and request.
    logic              wr;
    logic [BE_W-1:0]   be;
    periph_addr_t      addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;

    modport host (
        output wr,
        output be,
        output addr,
        output wdata,
        input  rdata
    );

    modport dev (
        input  wr,
        input  be,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== hdl/soc_pkg.sv ====
package soc_pkg;

    // Bus widths.
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int BE_W = DATA_W / 8;

    // Region field inside the data address.
    localparam int REGION_LSB = 13;
    localparam int REGION_MSB = 16;

    // Offset bits seen by one peripheral.
    localparam int PERIPH_ADDR_W = 13;

    localparam int GPIO_W = 16;

    // Interrupt ids.
    localparam int IRQ_ID_W = 5;
    localparam logic [IRQ_ID_W-1:0] TIMER_IRQ_ID = 5'd7;

    typedef logic [REGION_MSB-REGION_LSB:0] region_t;
    typedef logic [PERIPH_ADDR_W-1:0] periph_addr_t;

    // Merge the enabled byte lanes of a write into an old word.
    function automatic logic [DATA_W-1:0] byte_merge(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] wdata,
        input logic [BE_W-1:0]   be
    );
        logic [DATA_W-1:0] word;
        word = old_word;
        for (int i = 0; i < BE_W; i++) begin
            if (be[i]) begin
                word[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return word;
    endfunction

endpackage

// ==== include/soc_map.svh ====
`ifndef SOC_MAP_SVH
`define SOC_MAP_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Bus regions, address bits 16..13.
// ~~~~~~~~~~~~~~~~~~~~

// Data RAM, also holds the boot image.
`define REGION_DMEM     4'd0

// Instruction RAM, write-only from the data side.
`define REGION_IMEM     4'd2

`define REGION_TIMER    4'd6
`define REGION_GPIO     4'd8

// ~~~~~~~~~~~~~~~~~~~~
// Peripheral register byte offsets.
// ~~~~~~~~~~~~~~~~~~~~

// Timer.
`define TMR_COUNT       13'h000
`define TMR_COMPARE     13'h004
`define TMR_CTRL        13'h008

// GPIO.
`define GPIO_OUT        13'h000
`define GPIO_IN         13'h004

`endif
